// ==== Bender.yml ====
package:
  name: coherent_mem_sys

sources:
  - source/cpu_port_pkg.sv
  - source/coh_bus_pkg.sv
  - source/l1_dcache.sv
  - source/bus_arbiter.sv
  - source/coh_bus_ctrl.sv
  - source/coherent_mem_sys.sv
  - target: test
    files:
      - bench/l2_mem_model.sv
      - bench/tb_coherent_mem_sys.sv

// ==== bench/l2_mem_model.sv ====
// Behavioral L2 memory for the coherent memory testbench
// Answers each read or write with a one-cycle ready after a random latency,
// counts reads and writes, and remembers the last write
`timescale 1ns/1ps
`default_nettype none

module l2_mem_model
    import cpu_port_pkg::*, coh_bus_pkg::*;
#(
    parameter int    DEPTH    = 256,
    parameter word_t FILL_XOR = 32'h5a5a0000,
    parameter int    LAT_MIN  = 1,
    parameter int    LAT_MAX  = 6
) (
    input  logic     CLK,
    input  logic     rst_n,
    input  l2_req_t  l2_req,
    output l2_resp_t l2_resp,
    output int       rd_count,
    output int       wr_count,
    output int       rd_count_at_wr,  // Reads seen when the last write landed
    output addr_t    last_wr_addr,
    output word_t    last_wr_data
);

    localparam int IDX_W = $clog2(DEPTH);

    word_t            mem [DEPTH];
    logic             busy_q;           // Request accepted, latency running
    int               wait_q;
    logic             ready_q;
    word_t            rdata_q;
    logic [IDX_W-1:0] idx;

    assign idx           = l2_req.addr[IDX_W-1:0];
    assign l2_resp.ready = ready_q;
    assign l2_resp.rdata = rdata_q;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            busy_q         <= 1'b0;
            wait_q         <= 0;
            ready_q        <= 1'b0;
            rdata_q        <= '0;
            rd_count       <= 0;
            wr_count       <= 0;
            rd_count_at_wr <= 0;
            last_wr_addr   <= '0;
            last_wr_data   <= '0;
            for (int i = 0; i < DEPTH; i++)
                mem[i] <= word_t'(i) ^ FILL_XOR;        // Word value follows its address
        end else begin
            ready_q <= 1'b0;
            if (!busy_q && !ready_q && (l2_req.rd || l2_req.wr)) begin
                busy_q <= 1'b1;
                wait_q <= $urandom_range(LAT_MAX, LAT_MIN) - 1;
            end else if (busy_q) begin
                if (wait_q == 0) begin
                    busy_q  <= 1'b0;
                    ready_q <= 1'b1;
                    if (l2_req.wr) begin
                        mem[idx]       <= l2_req.wdata;
                        wr_count       <= wr_count + 1;
                        rd_count_at_wr <= rd_count;
                        last_wr_addr   <= l2_req.addr;
                        last_wr_data   <= l2_req.wdata;
                    end else begin
                        rdata_q  <= mem[idx];
                        rd_count <= rd_count + 1;
                    end
                end else begin
                    wait_q <= wait_q - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== bench/tb_coherent_mem_sys.sv ====
// Testbench for the two-processor MESI memory subsystem
// Directed tests for cold reads, silent upgrade, dirty supply, shared write,
// eviction writeback and bus contention, plus a random burst of accesses
// checked against a per-address reference memory
`timescale 1ns/1ps
`default_nettype none

module tb_coherent_mem_sys
    import cpu_port_pkg::*, coh_bus_pkg::*;
();

    localparam int          NCPU           = 2;
    localparam int          LINES          = 4;
    localparam int          L2_DEPTH       = 256;
    localparam int          L2_LAT_MIN     = 1;
    localparam int          L2_LAT_MAX     = 6;
    localparam word_t       FILL_XOR       = 32'h5a5a0000;  // L2 start value is addr ^ this
    localparam logic [31:0] SEED           = 32'hd9fbd129;
    localparam int          TIMEOUT_CYCLES = 200;
    localparam addr_t       BURST_BASE     = 32'h80;
    localparam int          BURST_ROUNDS   = 48;

    logic      CLK;
    logic      rst_n;
    cpu_req_t  cpu_req  [NCPU];
    cpu_resp_t cpu_resp [NCPU];
    l2_req_t   l2_req;
    l2_resp_t  l2_resp;

    int    l2_rd_count, l2_wr_count, l2_rd_count_at_wr;
    addr_t l2_last_wr_addr;
    word_t l2_last_wr_data;

    word_t ref_mem [L2_DEPTH];   // Latest value written per address
    int    last_latency [NCPU];
    int    errors;
    int    checks;

    coherent_mem_sys #(
        .NCPU  (NCPU),
        .LINES (LINES)
    ) DUT (
        .CLK      (CLK),
        .rst_n    (rst_n),
        .cpu_req  (cpu_req),
        .cpu_resp (cpu_resp),
        .l2_req   (l2_req),
        .l2_resp  (l2_resp)
    );

    l2_mem_model #(
        .DEPTH    (L2_DEPTH),
        .FILL_XOR (FILL_XOR),
        .LAT_MIN  (L2_LAT_MIN),
        .LAT_MAX  (L2_LAT_MAX)
    ) u_l2 (
        .CLK            (CLK),
        .rst_n          (rst_n),
        .l2_req         (l2_req),
        .l2_resp        (l2_resp),
        .rd_count       (l2_rd_count),
        .wr_count       (l2_wr_count),
        .rd_count_at_wr (l2_rd_count_at_wr),
        .last_wr_addr   (l2_last_wr_addr),
        .last_wr_data   (l2_last_wr_data)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    task automatic check_value(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    // Hung request ends the run here
    task automatic stop_on_timeout(input int cpu);
        $display("Timeout: CPU%0d request did not complete in %0d cycles", cpu, TIMEOUT_CYCLES);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("RESULT: FAIL");
        $finish;
    endtask

    // Drive one request on the falling edge, hold it until busy is seen low
    task automatic request_and_wait(input int cpu, input logic is_wr, input addr_t addr,
                                    input word_t wdata, output word_t rdata);
        int cycles;
        cycles = 0;
        @(negedge CLK);
        cpu_req[cpu].rd    = !is_wr;
        cpu_req[cpu].wr    = is_wr;
        cpu_req[cpu].addr  = addr;
        cpu_req[cpu].wdata = wdata;
        do begin
            @(negedge CLK);
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                stop_on_timeout(cpu);
        end while (cpu_resp[cpu].busy);
        rdata             = cpu_resp[cpu].rdata;   // Completion cycle
        last_latency[cpu] = cycles;
        cpu_req[cpu].rd   = 1'b0;
        cpu_req[cpu].wr   = 1'b0;
    endtask

    task automatic cpu_read(input int cpu, input addr_t addr);
        word_t rdata;
        request_and_wait(cpu, 1'b0, addr, '0, rdata);
        check_value($sformatf("cpu_resp[%0d].rdata @0x%0h", cpu, addr), rdata,
                    ref_mem[addr]);
    endtask

    task automatic cpu_write(input int cpu, input addr_t addr, input word_t data);
        word_t unused;
        request_and_wait(cpu, 1'b1, addr, data, unused);
        ref_mem[addr] = data;
    endtask

    // I->E on a cold miss, then a hit with no L2 traffic
    task automatic cold_read_then_hit();
        int rd0, wr0;
        rd0 = l2_rd_count;
        wr0 = l2_wr_count;
        cpu_read(0, 32'h10);
        check_value("l2_rd_count", l2_rd_count, rd0 + 1);
        cpu_read(0, 32'h10);
        check_value("hit latency cpu0", last_latency[0], 1);
        check_value("l2_rd_count", l2_rd_count, rd0 + 1);
        check_value("l2_wr_count", l2_wr_count, wr0);
    endtask

    // Silent E->M, then the peer read pulls the dirty line and L2 gets it
    task automatic silent_upgrade_dirty_supply();
        int rd0, wr0;
        rd0 = l2_rd_count;
        wr0 = l2_wr_count;
        cpu_write(0, 32'h10, 32'hc0de_0001);
        check_value("write hit latency cpu0", last_latency[0], 1);
        check_value("l2_rd_count", l2_rd_count, rd0);
        check_value("l2_wr_count", l2_wr_count, wr0);
        cpu_read(1, 32'h10);
        check_value("l2_wr_count", l2_wr_count, wr0 + 1);
        check_value("l2_last_wr_addr", l2_last_wr_addr, 32'h10);
        check_value("l2_last_wr_data", l2_last_wr_data, 32'hc0de_0001);
        check_value("l2_rd_count", l2_rd_count, rd0);
    endtask

    // Both share, CPU1 upgrades S->M, CPU0 must see the new value
    task automatic shared_read_then_write();
        int wr0;
        cpu_read(0, 32'h21);
        cpu_read(1, 32'h21);
        cpu_write(1, 32'h21, 32'hbeef_0021);
        wr0 = l2_wr_count;
        cpu_read(0, 32'h21);
        check_value("l2_wr_count", l2_wr_count, wr0 + 1);   // Dirty supply from CPU1
    endtask

    // Dirty victim goes to L2 ahead of the conflicting fetch
    task automatic eviction_writeback();
        int rd0, wr0;
        cpu_write(0, 32'h32, 32'hfeed_0032);
        rd0 = l2_rd_count;
        wr0 = l2_wr_count;
        cpu_read(0, 32'h32 + LINES);
        check_value("l2_wr_count", l2_wr_count, wr0 + 1);
        check_value("l2_last_wr_addr", l2_last_wr_addr, 32'h32);
        check_value("l2_last_wr_data", l2_last_wr_data, 32'hfeed_0032);
        check_value("l2_rd_count_at_wr", l2_rd_count_at_wr, rd0);  // Write came first
        check_value("l2_rd_count", l2_rd_count, rd0 + 1);
    endtask

    // Same-cycle misses, then a random two-CPU burst over 8 addresses
    task automatic contention_and_burst();
        int    o0, o1;
        logic  w0, w1;
        word_t d0, d1;
        fork
            cpu_write(0, 32'h43, 32'h1234_0043);
            cpu_read(1, 32'h57);
        join
        cpu_read(1, 32'h43);
        for (int r = 0; r < BURST_ROUNDS; r++) begin
            o0 = $urandom_range(7, 0);
            o1 = $urandom_range(7, 0);
            w0 = $urandom_range(1, 0);
            w1 = $urandom_range(1, 0);
            d0 = $urandom;
            d1 = $urandom;
            if (o0 == o1 && (w0 || w1))
                o1 = (o1 + 1) % 8;   // No same-address race with a write
            fork
                begin
                    if (w0) cpu_write(0, BURST_BASE + o0, d0);
                    else    cpu_read(0, BURST_BASE + o0);
                end
                begin
                    if (w1) cpu_write(1, BURST_BASE + o1, d1);
                    else    cpu_read(1, BURST_BASE + o1);
                end
            join
        end
        for (int a = 0; a < 8; a++) begin
            cpu_read(0, BURST_BASE + a);
            cpu_read(1, BURST_BASE + a);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        errors = 0;
        checks = 0;
        rst_n  = 1'b0;
        for (int i = 0; i < NCPU; i++) begin
            cpu_req[i]      = '0;
            last_latency[i] = 0;
        end
        for (int i = 0; i < L2_DEPTH; i++)
            ref_mem[i] = word_t'(i) ^ FILL_XOR;
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        rst_n = 1'b1;
        cold_read_then_hit();
        silent_upgrade_dirty_supply();
        shared_read_then_write();
        eviction_writeback();
        contention_and_burst();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
source/cpu_port_pkg.sv
source/coh_bus_pkg.sv
source/l1_dcache.sv
source/bus_arbiter.sv
source/coh_bus_ctrl.sv
source/coherent_mem_sys.sv
bench/l2_mem_model.sv
bench/tb_coherent_mem_sys.sv

// ==== source/bus_arbiter.sv ====
// Round-robin arbiter for the shared snooping bus
// A grant is locked when taken and held until the release pulse;
// priority then starts at the cache after the last owner.
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter #(
    parameter int NCPU = 2
) (
    input  logic                    CLK,
    input  logic                    rst_n,
    input  logic [NCPU-1:0]         req,
    input  logic                    grant_release,  // Done pulse of the current owner
    output logic                    grant_valid,
    output logic [$clog2(NCPU)-1:0] grant_id
);

    localparam int IDW = $clog2(NCPU);

    logic           lock_q;
    logic [IDW-1:0] owner_q;
    logic [IDW-1:0] ptr_q;    // Highest priority slot
    logic [IDW-1:0] winner;
    logic           found;

    // First requester at or after the pointer
    always_comb begin
        int idx;
        winner = ptr_q;
        found  = 1'b0;
        for (int i = 0; i < NCPU; i++) begin
            idx = (int'(ptr_q) + i) % NCPU;
            if (!found && req[idx]) begin
                found  = 1'b1;
                winner = IDW'(idx);
            end
        end
    end

    // Free bus grants in the same cycle so a new owner can follow done directly
    assign grant_valid = lock_q || found;
    assign grant_id    = lock_q ? owner_q : winner;

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            lock_q  <= 1'b0;
            owner_q <= '0;
            ptr_q   <= '0;
        end else if (!lock_q && found) begin
            lock_q  <= 1'b1;                                // Grant taken
            owner_q <= winner;
        end else if (lock_q && grant_release) begin
            lock_q <= 1'b0;
            ptr_q  <= IDW'((int'(owner_q) + 1) % NCPU);     // Move past last winner
        end
    end

endmodule

`default_nettype wire

// ==== source/coh_bus_ctrl.sv ====
// Snooping bus controller
// Takes the granted cache request, snoops the peers and picks the data source:
// a clean peer, a dirty peer (also written back to L2), or L2 itself.
// Writebacks go straight to L2. The done pulse frees the arbiter.
`timescale 1ns/1ps
`default_nettype none

module coh_bus_ctrl
    import cpu_port_pkg::*, coh_bus_pkg::*;
#(
    parameter int NCPU = 2
) (
    input  logic        CLK,
    input  logic        rst_n,
    input  bus_req_t    bus_req    [NCPU],
    output bus_resp_t   bus_resp   [NCPU],
    output snoop_t      snoop      [NCPU],
    input  snoop_resp_t snoop_resp [NCPU],
    output l2_req_t     l2_req,
    input  l2_resp_t    l2_resp
);

    localparam int IDW = $clog2(NCPU);

    typedef enum logic [2:0] {
        IDLE, SNOOP, COLLECT, PEER_XFER, L2_WRITE, L2_READ, RESPOND
    } state_t;

    state_t          state_q;
    logic [NCPU-1:0] req_vec;
    logic            grant_valid;
    logic [IDW-1:0]  grant_id;
    logic [IDW-1:0]  owner_q;     // Requester being served
    bus_req_t        req_q;       // Captured request
    word_t           data_q;      // Data returned with done, or written to L2
    logic            shared_q;
    logic            done;

    // Combined peer answers
    logic  any_hit;
    logic  any_dirty;
    word_t peer_data;

    always_comb begin
        for (int i = 0; i < NCPU; i++)
            req_vec[i] = bus_req[i].valid;
    end

    assign done = (state_q == PEER_XFER) || (state_q == RESPOND);

    bus_arbiter #(
        .NCPU (NCPU)
    ) u_arbiter (
        .CLK           (CLK),
        .rst_n         (rst_n),
        .req           (req_vec),
        .grant_release (done),
        .grant_valid   (grant_valid),
        .grant_id      (grant_id)
    );

    // OR of peer answers, requester masked out
    always_comb begin
        any_hit   = 1'b0;
        any_dirty = 1'b0;
        peer_data = '0;
        for (int i = 0; i < NCPU; i++) begin
            if (owner_q != IDW'(i) && snoop_resp[i].hit) begin
                any_hit   = 1'b1;
                any_dirty = any_dirty || snoop_resp[i].dirty;
                peer_data = peer_data | snoop_resp[i].data;  // Clean copies agree
            end
        end
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= IDLE;
            owner_q  <= '0;
            shared_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (grant_valid) begin
                        owner_q  <= grant_id;
                        shared_q <= 1'b0;
                        state_q  <= (bus_req[grant_id].cmd == BUS_WB) ? L2_WRITE : SNOOP;
                    end
                end
                SNOOP:   state_q <= COLLECT;                  // Pulse goes out this cycle
                COLLECT: begin
                    shared_q <= any_hit;
                    if (any_dirty)
                        state_q <= L2_WRITE;                  // Dirty peer data to L2 first
                    else if (any_hit)
                        state_q <= PEER_XFER;
                    else
                        state_q <= L2_READ;
                end
                L2_WRITE: if (l2_resp.ready) state_q <= RESPOND;
                L2_READ:  if (l2_resp.ready) state_q <= RESPOND;
                default:  state_q <= IDLE;                    // PEER_XFER, RESPOND
            endcase
        end
    end

    // Payload capture
    always_ff @(posedge CLK) begin
        if (state_q == IDLE && grant_valid) begin
            req_q  <= bus_req[grant_id];
            data_q <= bus_req[grant_id].data;             // Writeback data
        end
        if (state_q == COLLECT)
            data_q <= peer_data;
        if (state_q == L2_READ && l2_resp.ready)
            data_q <= l2_resp.rdata;
    end

    always_comb begin
        for (int i = 0; i < NCPU; i++) begin
            bus_resp[i].done   = done && (owner_q == IDW'(i));  // Requester only
            bus_resp[i].shared = shared_q;
            bus_resp[i].data   = data_q;
            snoop[i].valid     = (state_q == SNOOP) && (owner_q != IDW'(i));
            snoop[i].cmd       = req_q.cmd;
            snoop[i].addr      = req_q.addr;
        end
    end

    assign l2_req.rd    = (state_q == L2_READ);
    assign l2_req.wr    = (state_q == L2_WRITE);
    assign l2_req.addr  = req_q.addr;
    assign l2_req.wdata = data_q;

endmodule

`default_nettype wire

// ==== source/coh_bus_pkg.sv ====
// Shared snooping bus definitions
// MESI line states, bus commands, and the request, response, snoop and L2 structs
`default_nettype none

package coh_bus_pkg;

    import cpu_port_pkg::*;

    // INVALID is zero so a cleared state array reads as empty
    typedef enum logic [1:0] {
        INVALID   = 2'b00,
        SHARED    = 2'b01,
        EXCLUSIVE = 2'b10,
        MODIFIED  = 2'b11
    } mesi_t;

    typedef enum logic [1:0] {
        BUS_RD  = 2'b00,  // Read for sharing
        BUS_RDX = 2'b01,  // Read for ownership, peers invalidate
        BUS_WB  = 2'b10   // Victim writeback, never snooped
    } bus_cmd_t;

    typedef struct packed {
        logic     valid;  // Level, held with the fields until done
        bus_cmd_t cmd;
        addr_t    addr;
        word_t    data;   // Writeback data
    } bus_req_t;

    typedef struct packed {
        logic  done;      // One-cycle pulse to the requester only
        logic  shared;    // Some peer kept a copy
        word_t data;
    } bus_resp_t;

    typedef struct packed {
        logic     valid;  // One-cycle broadcast
        bus_cmd_t cmd;
        addr_t    addr;
    } snoop_t;

    // Returned one cycle after the snoop pulse
    typedef struct packed {
        logic  hit;
        logic  dirty;     // Line was MODIFIED
        word_t data;
    } snoop_resp_t;

    typedef struct packed {
        logic  rd;        // Held until ready
        logic  wr;
        addr_t addr;
        word_t wdata;
    } l2_req_t;

    typedef struct packed {
        logic  ready;     // One-cycle pulse
        word_t rdata;     // Valid with ready
    } l2_resp_t;

endpackage

`default_nettype wire

// ==== source/coherent_mem_sys.sv ====
// Two-level coherent memory subsystem top
// One direct-mapped L1 per processor, all peers on one snooping bus;
// the bus controller talks to an external L2 port
`timescale 1ns/1ps
`default_nettype none

module coherent_mem_sys
    import cpu_port_pkg::*, coh_bus_pkg::*;
#(
    parameter int NCPU  = 2,
    parameter int LINES = 4
) (
    input  logic      CLK,
    input  logic      rst_n,
    input  cpu_req_t  cpu_req  [NCPU],
    output cpu_resp_t cpu_resp [NCPU],
    output l2_req_t   l2_req,
    input  l2_resp_t  l2_resp
);

    // Cache to bus wiring, one entry per processor
    bus_req_t    bus_req    [NCPU];
    bus_resp_t   bus_resp   [NCPU];
    snoop_t      snoop      [NCPU];
    snoop_resp_t snoop_resp [NCPU];

    for (genvar i = 0; i < NCPU; i++) begin : g_cache
        l1_dcache #(
            .LINES (LINES)
        ) u_l1 (
            .CLK        (CLK),
            .rst_n      (rst_n),
            .cpu_req    (cpu_req[i]),
            .cpu_resp   (cpu_resp[i]),
            .bus_req    (bus_req[i]),
            .bus_resp   (bus_resp[i]),
            .snoop      (snoop[i]),
            .snoop_resp (snoop_resp[i])
        );
    end

    coh_bus_ctrl #(
        .NCPU (NCPU)
    ) u_bus_ctrl (
        .CLK        (CLK),
        .rst_n      (rst_n),
        .bus_req    (bus_req),
        .bus_resp   (bus_resp),
        .snoop      (snoop),
        .snoop_resp (snoop_resp),
        .l2_req     (l2_req),
        .l2_resp    (l2_resp)
    );

endmodule

`default_nettype wire

// ==== source/cpu_port_pkg.sv ====
// Processor-side types of the coherent memory subsystem
// Word-addressed request and response seen by each L1 data cache
`default_nettype none

package cpu_port_pkg;

    localparam int ADDR_W = 32;  // Word address width
    localparam int WORD_W = 32;  // One block is one word

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [WORD_W-1:0] word_t;

    // Request is held steady until busy is seen low
    typedef struct packed {
        logic  rd;      // Load
        logic  wr;      // Store
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        logic  busy;    // Request present, not yet complete
        word_t rdata;   // Valid in the completion cycle of a read
    } cpu_resp_t;

endpackage

`default_nettype wire

// ==== source/l1_dcache.sv ====
// Direct-mapped L1 data cache with MESI line states
// Serves processor hits in one cycle, resolves misses and S-state writes
// over the shared bus, and answers snoops from peer caches in every state.
// One line holds one 32-bit word.
`timescale 1ns/1ps
`default_nettype none

module l1_dcache
    import cpu_port_pkg::*, coh_bus_pkg::*;
#(
    parameter int LINES = 4
) (
    input  logic        CLK,
    input  logic        rst_n,
    input  cpu_req_t    cpu_req,
    output cpu_resp_t   cpu_resp,
    output bus_req_t    bus_req,
    input  bus_resp_t   bus_resp,
    input  snoop_t      snoop,
    output snoop_resp_t snoop_resp
);

    localparam int IDX_W = $clog2(LINES);
    localparam int TAG_W = ADDR_W - IDX_W;

    typedef enum logic [1:0] {IDLE, WRITEBACK, FETCH, FINISH} state_t;

    // Line storage
    mesi_t            mesi_mem [LINES];
    logic [TAG_W-1:0] tag_mem  [LINES];
    word_t            data_mem [LINES];

    state_t state_q, next_state;

    // Processor side lookup
    logic [IDX_W-1:0] cpu_idx;
    logic [TAG_W-1:0] cpu_tag;
    mesi_t            line_mesi;
    logic             cpu_active;
    logic             cpu_hit;

    // Snoop side lookup
    logic [IDX_W-1:0] snp_idx;
    logic [TAG_W-1:0] snp_tag;
    mesi_t            snp_mesi;
    logic             snp_hit;
    logic             snp_conflict;

    // Line update controls from the FSM
    logic  line_we;
    word_t line_data;
    logic  mesi_we;
    mesi_t mesi_new;
    logic  rdata_ld;
    word_t rdata_nxt;
    word_t rdata_q;

    logic  snp_hit_q, snp_dirty_q;
    word_t snp_data_q;

    assign cpu_idx    = cpu_req.addr[IDX_W-1:0];
    assign cpu_tag    = cpu_req.addr[ADDR_W-1:IDX_W];
    assign line_mesi  = mesi_mem[cpu_idx];
    assign cpu_active = cpu_req.rd || cpu_req.wr;
    assign cpu_hit    = (line_mesi != INVALID) && (tag_mem[cpu_idx] == cpu_tag);

    assign snp_idx  = snoop.addr[IDX_W-1:0];
    assign snp_tag  = snoop.addr[ADDR_W-1:IDX_W];
    assign snp_mesi = mesi_mem[snp_idx];
    assign snp_hit  = (snp_mesi != INVALID) && (tag_mem[snp_idx] == snp_tag);
    // A snoop on the same set this cycle would race the lookup, so wait one cycle
    assign snp_conflict = snoop.valid && (snp_idx == cpu_idx);

    // Completion cycle is FINISH, where busy drops with rdata valid
    assign cpu_resp.busy  = cpu_active && (state_q != FINISH);
    assign cpu_resp.rdata = rdata_q;

    always_comb begin
        next_state = state_q;
        line_we    = 1'b0;
        line_data  = cpu_req.wdata;
        mesi_we    = 1'b0;
        mesi_new   = INVALID;
        rdata_ld   = 1'b0;
        rdata_nxt  = data_mem[cpu_idx];
        case (state_q)
            IDLE: begin
                if (cpu_active && !snp_conflict) begin
                    if (cpu_req.rd && cpu_hit) begin
                        rdata_ld   = 1'b1;                 // Read hit in any valid state
                        next_state = FINISH;
                    end else if (cpu_req.wr && cpu_hit && line_mesi != SHARED) begin
                        line_we    = 1'b1;                 // Silent E->M, or M stays M
                        mesi_we    = 1'b1;
                        mesi_new   = MODIFIED;
                        next_state = FINISH;
                    end else if (!cpu_hit && line_mesi == MODIFIED) begin
                        next_state = WRITEBACK;            // Dirty victim goes out first
                    end else begin
                        next_state = FETCH;                // Miss, or write on S
                    end
                end
            end
            WRITEBACK: begin
                if (bus_resp.done) begin
                    mesi_we    = 1'b1;                     // Victim now clean in L2
                    mesi_new   = INVALID;
                    next_state = FETCH;
                end
            end
            FETCH: begin
                if (bus_resp.done) begin
                    line_we   = 1'b1;
                    line_data = cpu_req.wr ? cpu_req.wdata : bus_resp.data;  // Merge store
                    mesi_we   = 1'b1;
                    if (cpu_req.wr)
                        mesi_new = MODIFIED;
                    else if (bus_resp.shared)
                        mesi_new = SHARED;
                    else
                        mesi_new = EXCLUSIVE;
                    rdata_ld   = 1'b1;
                    rdata_nxt  = bus_resp.data;
                    next_state = FINISH;
                end
            end
            default: next_state = IDLE;                    // FINISH lasts one cycle
        endcase
    end

    // Bus request follows the FSM state
    always_comb begin
        bus_req.valid = (state_q == WRITEBACK) || (state_q == FETCH);
        if (state_q == WRITEBACK) begin
            bus_req.cmd  = BUS_WB;
            bus_req.addr = {tag_mem[cpu_idx], cpu_idx};  // Victim address
            bus_req.data = data_mem[cpu_idx];
        end else begin
            bus_req.cmd  = cpu_req.wr ? BUS_RDX : BUS_RD;
            bus_req.addr = cpu_req.addr;
            bus_req.data = cpu_req.wdata;
        end
    end

    // Control state and MESI array
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= IDLE;
            snp_hit_q   <= 1'b0;
            snp_dirty_q <= 1'b0;
            for (int i = 0; i < LINES; i++)
                mesi_mem[i] <= INVALID;
        end else begin
            state_q <= next_state;
            if (mesi_we)
                mesi_mem[cpu_idx] <= mesi_new;
            snp_hit_q   <= snoop.valid && snp_hit;
            snp_dirty_q <= snoop.valid && snp_hit && (snp_mesi == MODIFIED);
            // Snoop state change lands with the answer
            if (snoop.valid && snp_hit) begin
                if (snoop.cmd == BUS_RDX)
                    mesi_mem[snp_idx] <= INVALID;
                else if (snoop.cmd == BUS_RD && snp_mesi != SHARED)
                    mesi_mem[snp_idx] <= SHARED;            // M->S, E->S
            end
        end
    end

    // Tags, data and read data
    always_ff @(posedge CLK) begin
        if (line_we) begin
            tag_mem[cpu_idx]  <= cpu_tag;
            data_mem[cpu_idx] <= line_data;
        end
        if (rdata_ld)
            rdata_q <= rdata_nxt;
        snp_data_q <= data_mem[snp_idx];
    end

    assign snoop_resp.hit   = snp_hit_q;
    assign snoop_resp.dirty = snp_dirty_q;
    assign snoop_resp.data  = snp_data_q;

endmodule

`default_nettype wire
